// File: rtl/id_pkg.sv
package id_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int LINK_REG   = 31;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// primary opcode field, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_e;

	// function field of special instructions, inst[5:0]
	typedef enum logic [5:0] {
		FN_JR   = 6'b001000,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// immediate forms share the register op code
	typedef enum logic [4:0] {
		ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
		ALU_LUI, ALU_LW, ALU_SW, ALU_JAL, ALU_BRANCH
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BGTZ, BR_BLEZ, BR_J, BR_JAL, BR_JR
	} br_kind_e;

	typedef enum logic [1:0] {
		IMM_REG, IMM_ZERO_EXT, IMM_SIGN_EXT
	} imm_kind_e;

	typedef struct packed {
		logic      we;
		reg_addr_t addr;
		word_t     data;
	} reg_write_t;

	typedef struct packed {
		alu_op_e   alu_op;
		br_kind_e  br_kind;
		imm_kind_e imm_kind;
		logic      rs_read;
		logic      rt_read;
		logic      is_store;
		reg_addr_t dest;
		logic      we;
	} dec_ctrl_t;

	typedef struct packed {
		alu_op_e   alu_op;
		word_t     operand1;
		word_t     operand2;
		reg_addr_t dest;
		logic      we;
	} issue_t;

	localparam dec_ctrl_t DEC_NOP = '{alu_op: ALU_NOP, br_kind: BR_NONE, imm_kind: IMM_REG,
		rs_read: 1'b0, rt_read: 1'b0, is_store: 1'b0, dest: '0, we: 1'b0};

	localparam issue_t ISSUE_NOP = '{alu_op: ALU_NOP, operand1: '0, operand2: '0,
		dest: '0, we: 1'b0};

endpackage

// File: rtl/regfile.sv
module regfile (
	input  logic               clk,
	input  logic               reset_i,
	input  id_pkg::reg_write_t wr_i,
	input  id_pkg::reg_addr_t  rd_addr_a_i,
	input  id_pkg::reg_addr_t  rd_addr_b_i,
	output id_pkg::word_t      rd_data_a_o,
	output id_pkg::word_t      rd_data_b_o
);
	import id_pkg::*;

	word_t regs [NUM_REGS];

	// r0 reads zero, same-cycle write is bypassed
	function automatic word_t read_port(input reg_addr_t addr, input reg_write_t wr,
			input word_t stored);
		word_t val;
		if (addr == '0) begin
			val = '0;
		end else if (wr.we && wr.addr == addr) begin
			val = wr.data;
		end else begin
			val = stored;
		end
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_i.we && wr_i.addr != '0) begin
			regs[wr_i.addr] <= wr_i.data;
		end
	end

	assign rd_data_a_o = read_port(rd_addr_a_i, wr_i, regs[rd_addr_a_i]);
	assign rd_data_b_o = read_port(rd_addr_b_i, wr_i, regs[rd_addr_b_i]);

endmodule

// File: rtl/inst_decoder.sv
module inst_decoder (
	input  id_pkg::word_t     inst_i,
	output id_pkg::dec_ctrl_t ctrl_o
);
	import id_pkg::*;

	opcode_e   opcode;
	funct_e    funct;
	reg_addr_t rt;
	reg_addr_t rd;

	assign opcode = opcode_e'(inst_i[31:26]);
	assign funct  = funct_e'(inst_i[5:0]);
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];

	// rs op rt -> rd
	function automatic dec_ctrl_t r_type(input alu_op_e op, input reg_addr_t dst);
		dec_ctrl_t c;
		c = DEC_NOP;
		c.alu_op  = op;
		c.rs_read = 1'b1;
		c.rt_read = 1'b1;
		c.dest    = dst;
		c.we      = 1'b1;
		return c;
	endfunction

	// rs op imm -> rt
	function automatic dec_ctrl_t i_type(input alu_op_e op, input imm_kind_e kind,
			input reg_addr_t dst);
		dec_ctrl_t c;
		c = DEC_NOP;
		c.alu_op   = op;
		c.imm_kind = kind;
		c.rs_read  = 1'b1;
		c.dest     = dst;
		c.we       = 1'b1;
		return c;
	endfunction

	// branch or jump, writes nothing
	function automatic dec_ctrl_t br_type(input br_kind_e kind, input logic use_rs,
			input logic use_rt);
		dec_ctrl_t c;
		c = DEC_NOP;
		c.alu_op  = ALU_BRANCH;
		c.br_kind = kind;
		c.rs_read = use_rs;
		c.rt_read = use_rt;
		return c;
	endfunction

	always_comb begin
		ctrl_o = DEC_NOP;
		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FN_AND:  ctrl_o = r_type(ALU_AND, rd);
					FN_OR:   ctrl_o = r_type(ALU_OR, rd);
					FN_XOR:  ctrl_o = r_type(ALU_XOR, rd);
					FN_NOR:  ctrl_o = r_type(ALU_NOR, rd);
					FN_ADD:  ctrl_o = r_type(ALU_ADD, rd);
					FN_ADDU: ctrl_o = r_type(ALU_ADDU, rd);
					FN_SUB:  ctrl_o = r_type(ALU_SUB, rd);
					FN_SUBU: ctrl_o = r_type(ALU_SUBU, rd);
					FN_SLT:  ctrl_o = r_type(ALU_SLT, rd);
					FN_SLTU: ctrl_o = r_type(ALU_SLTU, rd);
					FN_JR:   ctrl_o = br_type(BR_JR, 1'b1, 1'b0);
					default: ctrl_o = DEC_NOP;
				endcase
			end
			OP_ANDI:  ctrl_o = i_type(ALU_AND, IMM_ZERO_EXT, rt);
			OP_ORI:   ctrl_o = i_type(ALU_OR, IMM_ZERO_EXT, rt);
			OP_XORI:  ctrl_o = i_type(ALU_XOR, IMM_ZERO_EXT, rt);
			OP_ADDI:  ctrl_o = i_type(ALU_ADD, IMM_SIGN_EXT, rt);
			OP_ADDIU: ctrl_o = i_type(ALU_ADDU, IMM_SIGN_EXT, rt);
			OP_SLTI:  ctrl_o = i_type(ALU_SLT, IMM_SIGN_EXT, rt);
			OP_SLTIU: ctrl_o = i_type(ALU_SLTU, IMM_SIGN_EXT, rt);
			OP_LW:    ctrl_o = i_type(ALU_LW, IMM_SIGN_EXT, rt);
			OP_LUI: begin
				ctrl_o = i_type(ALU_LUI, IMM_ZERO_EXT, rt);
				ctrl_o.rs_read = 1'b0;
			end
			OP_SW: begin
				// address formed here, rt is the store data
				ctrl_o = DEC_NOP;
				ctrl_o.alu_op   = ALU_SW;
				ctrl_o.rs_read  = 1'b1;
				ctrl_o.rt_read  = 1'b1;
				ctrl_o.is_store = 1'b1;
			end
			OP_BEQ:  ctrl_o = br_type(BR_BEQ, 1'b1, 1'b1);
			OP_BNE:  ctrl_o = br_type(BR_BNE, 1'b1, 1'b1);
			OP_BGTZ: ctrl_o = br_type(BR_BGTZ, 1'b1, 1'b0);
			OP_BLEZ: ctrl_o = br_type(BR_BLEZ, 1'b1, 1'b0);
			OP_J:    ctrl_o = br_type(BR_J, 1'b0, 1'b0);
			OP_JAL: begin
				ctrl_o = br_type(BR_JAL, 1'b0, 1'b0);
				ctrl_o.alu_op = ALU_JAL;
				ctrl_o.dest   = reg_addr_t'(LINK_REG);
				ctrl_o.we     = 1'b1;
			end
			default: ctrl_o = DEC_NOP;
		endcase
	end

endmodule

// File: rtl/forwarding_unit.sv
module forwarding_unit (
	input  logic               inst_valid_i,
	input  id_pkg::dec_ctrl_t  ctrl_i,
	input  id_pkg::reg_addr_t  rs_addr_i,
	input  id_pkg::reg_addr_t  rt_addr_i,
	input  id_pkg::word_t      rs_raw_i,
	input  id_pkg::word_t      rt_raw_i,
	input  id_pkg::reg_write_t ex_fwd_i,
	input  id_pkg::reg_write_t mem_fwd_i,
	input  logic               ex_is_load_i,
	output id_pkg::word_t      rs_val_o,
	output id_pkg::word_t      rt_val_o,
	output logic               stall_o
);
	import id_pkg::*;

	logic rs_load_dep;
	logic rt_load_dep;

	// EX over MEM over regfile; unread sources and r0 give zero
	function automatic word_t pick(input logic rd_en, input reg_addr_t addr,
			input word_t raw, input reg_write_t ex, input reg_write_t mem);
		word_t val;
		if (!rd_en || addr == '0) begin
			val = '0;
		end else if (ex.we && ex.addr == addr) begin
			val = ex.data;
		end else if (mem.we && mem.addr == addr) begin
			val = mem.data;
		end else begin
			val = raw;
		end
		return val;
	endfunction

	assign rs_val_o = pick(ctrl_i.rs_read, rs_addr_i, rs_raw_i, ex_fwd_i, mem_fwd_i);
	assign rt_val_o = pick(ctrl_i.rt_read, rt_addr_i, rt_raw_i, ex_fwd_i, mem_fwd_i);

	// load data only exists after MEM, so EX forwarding cannot cover it
	assign rs_load_dep = ctrl_i.rs_read && ex_fwd_i.addr == rs_addr_i;
	assign rt_load_dep = ctrl_i.rt_read && ex_fwd_i.addr == rt_addr_i;

	assign stall_o = inst_valid_i && ex_is_load_i && ex_fwd_i.addr != '0
		&& (rs_load_dep || rt_load_dep);

endmodule

// File: rtl/branch_resolver.sv
module branch_resolver (
	input  logic              accept_i,
	input  id_pkg::dec_ctrl_t ctrl_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     inst_i,
	input  id_pkg::word_t     rs_val_i,
	input  id_pkg::word_t     rt_val_i,
	output logic              branch_taken_o,
	output id_pkg::word_t     branch_target_o
);
	import id_pkg::*;

	word_t pc_plus_4;
	word_t br_offset;
	word_t jump_target;
	logic  taken;
	word_t target;

	assign pc_plus_4   = pc_i + 32'd4;
	assign br_offset   = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
	assign jump_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};

	always_comb begin
		taken  = 1'b0;
		target = pc_plus_4 + br_offset;
		case (ctrl_i.br_kind)
			BR_BEQ:  taken = rs_val_i == rt_val_i;
			BR_BNE:  taken = rs_val_i != rt_val_i;
			// signed compare against zero
			BR_BGTZ: taken = $signed(rs_val_i) > 0;
			BR_BLEZ: taken = $signed(rs_val_i) <= 0;
			BR_J, BR_JAL: begin
				taken  = 1'b1;
				target = jump_target;
			end
			BR_JR: begin
				taken  = 1'b1;
				target = rs_val_i;
			end
			default: taken = 1'b0;
		endcase
	end

	// nothing leaves the stage unless the instruction is accepted
	assign branch_taken_o  = accept_i && taken;
	assign branch_target_o = branch_taken_o ? target : '0;

endmodule

// File: rtl/ex_issue_reg.sv
module ex_issue_reg (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              accept_i,
	input  id_pkg::dec_ctrl_t ctrl_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     inst_i,
	input  id_pkg::word_t     rs_val_i,
	input  id_pkg::word_t     rt_val_i,
	output id_pkg::issue_t    ex_o,
	output logic              ex_valid_o
);
	import id_pkg::*;

	word_t  imm_sext;
	word_t  imm_zext;
	issue_t next;

	assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
	assign imm_zext = {16'b0, inst_i[15:0]};

	always_comb begin
		next.alu_op = ctrl_i.alu_op;
		next.dest   = ctrl_i.dest;
		next.we     = ctrl_i.we;

		// operand1
		if (ctrl_i.alu_op == ALU_LUI) begin
			next.operand1 = '0;
		end else if (ctrl_i.alu_op == ALU_JAL) begin
			// link address past the delay slot
			next.operand1 = pc_i + 32'd8;
		end else if (ctrl_i.is_store) begin
			next.operand1 = rs_val_i + imm_sext;
		end else begin
			next.operand1 = rs_val_i;
		end

		// operand2
		case (ctrl_i.imm_kind)
			IMM_ZERO_EXT: next.operand2 = imm_zext;
			IMM_SIGN_EXT: next.operand2 = imm_sext;
			default:      next.operand2 = rt_val_i;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex_o       <= ISSUE_NOP;
			ex_valid_o <= 1'b0;
		end else begin
			ex_valid_o <= accept_i;
			if (accept_i) begin
				ex_o <= next;
			end
		end
	end

endmodule

// File: rtl/id_stage_top.sv
module id_stage_top (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               inst_valid_i,
	input  id_pkg::word_t      pc_i,
	input  id_pkg::word_t      inst_i,
	input  id_pkg::reg_write_t ex_fwd_i,
	input  id_pkg::reg_write_t mem_fwd_i,
	input  id_pkg::reg_write_t wb_i,
	input  logic               ex_is_load_i,
	output logic               stall_o,
	output logic               branch_taken_o,
	output id_pkg::word_t      branch_target_o,
	output id_pkg::issue_t     ex_o,
	output logic               ex_valid_o
);
	import id_pkg::*;

	dec_ctrl_t ctrl;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	word_t     rs_raw;
	word_t     rt_raw;
	word_t     rs_val;
	word_t     rt_val;
	logic      accept;

	assign rs_addr = inst_i[25:21];
	assign rt_addr = inst_i[20:16];
	assign accept  = inst_valid_i && !stall_o;

	regfile u_regfile (
		.clk         (clk),
		.reset_i     (reset_i),
		.wr_i        (wb_i),
		.rd_addr_a_i (rs_addr),
		.rd_addr_b_i (rt_addr),
		.rd_data_a_o (rs_raw),
		.rd_data_b_o (rt_raw)
	);

	inst_decoder u_decoder (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	forwarding_unit u_fwd (
		.inst_valid_i (inst_valid_i),
		.ctrl_i       (ctrl),
		.rs_addr_i    (rs_addr),
		.rt_addr_i    (rt_addr),
		.rs_raw_i     (rs_raw),
		.rt_raw_i     (rt_raw),
		.ex_fwd_i     (ex_fwd_i),
		.mem_fwd_i    (mem_fwd_i),
		.ex_is_load_i (ex_is_load_i),
		.rs_val_o     (rs_val),
		.rt_val_o     (rt_val),
		.stall_o      (stall_o)
	);

	branch_resolver u_branch (
		.accept_i        (accept),
		.ctrl_i          (ctrl),
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.rs_val_i        (rs_val),
		.rt_val_i        (rt_val),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o)
	);

	ex_issue_reg u_issue (
		.clk        (clk),
		.reset_i    (reset_i),
		.accept_i   (accept),
		.ctrl_i     (ctrl),
		.pc_i       (pc_i),
		.inst_i     (inst_i),
		.rs_val_i   (rs_val),
		.rt_val_i   (rt_val),
		.ex_o       (ex_o),
		.ex_valid_o (ex_valid_o)
	);

endmodule

// File: tests/tb_id_stage.sv
module tb_id_stage;
	timeunit 1ns;
	timeprecision 100ps;
	import id_pkg::*;

	typedef struct packed {
		reg_write_t wb;
		reg_write_t ex_fwd;
		reg_write_t mem_fwd;
		logic       ex_load;
		logic       valid;
		word_t      pc;
		word_t      inst;
		logic       exp_stall;
		logic       exp_taken;
		word_t      exp_target;
		logic       exp_valid;
		issue_t     exp_issue;
	} row_t;

	localparam word_t PC0 = 32'h0000_1000;

	logic       clk;
	logic       reset_i;
	logic       inst_valid_i;
	word_t      pc_i;
	word_t      inst_i;
	reg_write_t ex_fwd_i;
	reg_write_t mem_fwd_i;
	reg_write_t wb_i;
	logic       ex_is_load_i;
	logic       stall_o;
	logic       branch_taken_o;
	word_t      branch_target_o;
	issue_t     ex_o;
	logic       ex_valid_o;

	row_t  rows[$];
	string names[$];
	row_t  ctx;
	word_t model [NUM_REGS];
	int    errors = 0;
	int    row_errors = 0;
	int    passed = 0;
	int    failed = 0;
	int    cycles = 0;
	int    limit = 0;

	id_stage_top uut (
		.clk             (clk),
		.reset_i         (reset_i),
		.inst_valid_i    (inst_valid_i),
		.pc_i            (pc_i),
		.inst_i          (inst_i),
		.ex_fwd_i        (ex_fwd_i),
		.mem_fwd_i       (mem_fwd_i),
		.wb_i            (wb_i),
		.ex_is_load_i    (ex_is_load_i),
		.stall_o         (stall_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o),
		.ex_o            (ex_o),
		.ex_valid_o      (ex_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic word_t xorshift32(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t sign_extend16(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic word_t encode_rtype(input reg_addr_t rs, input reg_addr_t rt,
			input reg_addr_t rd, input funct_e fn);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t encode_itype(input opcode_e op, input reg_addr_t rs,
			input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t encode_jump(input opcode_e op, input logic [25:0] index);
		return {op, index};
	endfunction

	// pc + 4 + offset in words
	function automatic word_t branch_dest(input word_t pc, input logic [15:0] imm);
		return pc + 32'd4 + (sign_extend16(imm) << 2);
	endfunction

	function automatic word_t jump_dest(input word_t pc, input logic [25:0] index);
		word_t nxt;
		nxt = pc + 32'd4;
		return {nxt[31:28], index, 2'b00};
	endfunction

	function automatic issue_t mk_issue(input alu_op_e op, input word_t op1, input word_t op2,
			input reg_addr_t dest, input logic we);
		issue_t t;
		t.alu_op   = op;
		t.operand1 = op1;
		t.operand2 = op2;
		t.dest     = dest;
		t.we       = we;
		return t;
	endfunction

	task automatic check_issue(input string sig, input issue_t got, input issue_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: %s got %h expected %h", $time, sig, got, exp);
			errors++;
			row_errors++;
		end
	endtask

	task automatic check_word(input string sig, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: %s got %h expected %h", $time, sig, got, exp);
			errors++;
			row_errors++;
		end
	endtask

	task automatic check_bit(input string sig, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: %s got %b expected %b", $time, sig, got, exp);
			errors++;
			row_errors++;
		end
	endtask

	task automatic preload(input reg_addr_t idx, input word_t val);
		row_t r;
		r = '0;
		r.wb = '{1'b1, idx, val};
		rows.push_back(r);
		names.push_back($sformatf("preload r%0d", idx));
		model[idx] = val;
	endtask

	// forwarding and writeback inputs come from ctx
	task automatic add_row(input string name, input word_t pc, input word_t inst,
			input logic stall, input logic taken, input word_t target, input issue_t exp);
		row_t r;
		r = ctx;
		r.valid      = 1'b1;
		r.pc         = pc;
		r.inst       = inst;
		r.exp_stall  = stall;
		r.exp_taken  = taken;
		r.exp_target = target;
		r.exp_valid  = !stall;
		r.exp_issue  = exp;
		rows.push_back(r);
		names.push_back(name);
		ctx = '0;
	endtask

	task automatic set_fwd(input reg_write_t ex, input reg_write_t mem, input logic load);
		ctx.ex_fwd  = ex;
		ctx.mem_fwd = mem;
		ctx.ex_load = load;
	endtask

	task automatic build_table();
		word_t seed;
		word_t fa;
		word_t fb;
		word_t pcj;
		seed = 32'hccea_3844;
		fa   = 32'haaaa_0001;
		fb   = 32'hbbbb_0002;
		pcj  = 32'ha000_0010;
		ctx  = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			model[i] = '0;
		end
		// registers still hold their reset value
		add_row("read zero", PC0, encode_rtype(5'd1, 5'd2, 5'd3, FN_OR), 1'b0, 1'b0, '0,
			mk_issue(ALU_OR, '0, '0, 5'd3, 1'b1));
		for (int i = 1; i <= 8; i++) begin
			seed = xorshift32(seed);
			preload(reg_addr_t'(i), seed);
		end
		seed = xorshift32(seed);
		preload(5'd10, seed | 32'h8000_0000);
		seed = xorshift32(seed);
		preload(5'd12, (seed & 32'h7fff_ffff) | 32'h1);

		add_row("add", PC0, encode_rtype(5'd1, 5'd2, 5'd9, FN_ADD), 1'b0, 1'b0, '0,
			mk_issue(ALU_ADD, model[1], model[2], 5'd9, 1'b1));
		add_row("sub", PC0, encode_rtype(5'd3, 5'd4, 5'd9, FN_SUB), 1'b0, 1'b0, '0,
			mk_issue(ALU_SUB, model[3], model[4], 5'd9, 1'b1));
		add_row("slt", PC0, encode_rtype(5'd5, 5'd6, 5'd9, FN_SLT), 1'b0, 1'b0, '0,
			mk_issue(ALU_SLT, model[5], model[6], 5'd9, 1'b1));
		add_row("nor", PC0, encode_rtype(5'd7, 5'd8, 5'd9, FN_NOR), 1'b0, 1'b0, '0,
			mk_issue(ALU_NOR, model[7], model[8], 5'd9, 1'b1));
		add_row("ori", PC0, encode_itype(OP_ORI, 5'd1, 5'd9, 16'h8001), 1'b0, 1'b0, '0,
			mk_issue(ALU_OR, model[1], 32'h0000_8001, 5'd9, 1'b1));
		add_row("andi", PC0, encode_itype(OP_ANDI, 5'd2, 5'd9, 16'hf0f0), 1'b0, 1'b0, '0,
			mk_issue(ALU_AND, model[2], 32'h0000_f0f0, 5'd9, 1'b1));
		add_row("addi neg", PC0, encode_itype(OP_ADDI, 5'd3, 5'd9, 16'hfff0), 1'b0, 1'b0, '0,
			mk_issue(ALU_ADD, model[3], 32'hffff_fff0, 5'd9, 1'b1));
		add_row("sltiu", PC0, encode_itype(OP_SLTIU, 5'd4, 5'd9, 16'h8000), 1'b0, 1'b0, '0,
			mk_issue(ALU_SLTU, model[4], 32'hffff_8000, 5'd9, 1'b1));
		add_row("lui", PC0, encode_itype(OP_LUI, 5'd5, 5'd9, 16'h1234), 1'b0, 1'b0, '0,
			mk_issue(ALU_LUI, '0, 32'h0000_1234, 5'd9, 1'b1));
		add_row("unknown op", PC0, {6'b111111, 26'h3ff_ffff}, 1'b0, 1'b0, '0,
			mk_issue(ALU_NOP, '0, '0, 5'd0, 1'b0));

		set_fwd('{1'b1, 5'd1, fa}, '{1'b1, 5'd1, fb}, 1'b0);
		add_row("ex over mem", PC0, encode_rtype(5'd1, 5'd2, 5'd9, FN_ADD), 1'b0, 1'b0, '0,
			mk_issue(ALU_ADD, fa, model[2], 5'd9, 1'b1));
		set_fwd('{1'b1, 5'd5, fa}, '{1'b1, 5'd2, fb}, 1'b0);
		add_row("mem over rf", PC0, encode_rtype(5'd1, 5'd2, 5'd9, FN_ADD), 1'b0, 1'b0, '0,
			mk_issue(ALU_ADD, model[1], fb, 5'd9, 1'b1));
		set_fwd('{1'b1, 5'd0, fa}, '{1'b1, 5'd0, fb}, 1'b0);
		add_row("r0 no fwd", PC0, encode_rtype(5'd0, 5'd2, 5'd9, FN_ADD), 1'b0, 1'b0, '0,
			mk_issue(ALU_ADD, '0, model[2], 5'd9, 1'b1));
		ctx.wb = '{1'b1, 5'd6, 32'h1357_9bdf};
		add_row("wb bypass", PC0, encode_rtype(5'd6, 5'd7, 5'd9, FN_ADD), 1'b0, 1'b0, '0,
			mk_issue(ALU_ADD, 32'h1357_9bdf, model[7], 5'd9, 1'b1));
		model[6] = 32'h1357_9bdf;

		set_fwd('{1'b1, 5'd3, fa}, '0, 1'b1);
		add_row("load-use", PC0, encode_rtype(5'd3, 5'd4, 5'd9, FN_ADD), 1'b1, 1'b0, '0, '0);
		set_fwd('{1'b1, 5'd3, fa}, '0, 1'b1);
		add_row("load-use beq", PC0, encode_itype(OP_BEQ, 5'd3, 5'd3, 16'h0010),
			1'b1, 1'b0, '0, '0);
		set_fwd('{1'b1, 5'd0, fa}, '0, 1'b1);
		add_row("load r0", PC0, encode_rtype(5'd0, 5'd4, 5'd9, FN_ADD), 1'b0, 1'b0, '0,
			mk_issue(ALU_ADD, '0, model[4], 5'd9, 1'b1));
		set_fwd('{1'b1, 5'd5, fa}, '0, 1'b1);
		add_row("load unread", PC0, encode_itype(OP_ORI, 5'd1, 5'd5, 16'h00ff), 1'b0, 1'b0, '0,
			mk_issue(ALU_OR, model[1], 32'h0000_00ff, 5'd5, 1'b1));

		add_row("beq taken", PC0, encode_itype(OP_BEQ, 5'd1, 5'd1, 16'h0010), 1'b0, 1'b1,
			branch_dest(PC0, 16'h0010), mk_issue(ALU_BRANCH, model[1], model[1], 5'd0, 1'b0));
		add_row("beq not", PC0, encode_itype(OP_BEQ, 5'd1, 5'd2, 16'h0010), 1'b0, 1'b0, '0,
			mk_issue(ALU_BRANCH, model[1], model[2], 5'd0, 1'b0));
		add_row("bne taken", PC0, encode_itype(OP_BNE, 5'd1, 5'd2, 16'hfffe), 1'b0, 1'b1,
			branch_dest(PC0, 16'hfffe), mk_issue(ALU_BRANCH, model[1], model[2], 5'd0, 1'b0));
		add_row("bne not", PC0, encode_itype(OP_BNE, 5'd1, 5'd1, 16'hfffe), 1'b0, 1'b0, '0,
			mk_issue(ALU_BRANCH, model[1], model[1], 5'd0, 1'b0));
		// r10 negative, r11 zero, r12 positive
		add_row("bgtz neg", PC0, encode_itype(OP_BGTZ, 5'd10, 5'd0, 16'h0008), 1'b0, 1'b0, '0,
			mk_issue(ALU_BRANCH, model[10], '0, 5'd0, 1'b0));
		add_row("bgtz zero", PC0, encode_itype(OP_BGTZ, 5'd11, 5'd0, 16'h0008), 1'b0, 1'b0, '0,
			mk_issue(ALU_BRANCH, '0, '0, 5'd0, 1'b0));
		add_row("bgtz pos", PC0, encode_itype(OP_BGTZ, 5'd12, 5'd0, 16'h0008), 1'b0, 1'b1,
			branch_dest(PC0, 16'h0008), mk_issue(ALU_BRANCH, model[12], '0, 5'd0, 1'b0));
		add_row("blez neg", PC0, encode_itype(OP_BLEZ, 5'd10, 5'd0, 16'h0020), 1'b0, 1'b1,
			branch_dest(PC0, 16'h0020), mk_issue(ALU_BRANCH, model[10], '0, 5'd0, 1'b0));
		add_row("blez zero", PC0, encode_itype(OP_BLEZ, 5'd11, 5'd0, 16'h0020), 1'b0, 1'b1,
			branch_dest(PC0, 16'h0020), mk_issue(ALU_BRANCH, '0, '0, 5'd0, 1'b0));
		add_row("blez pos", PC0, encode_itype(OP_BLEZ, 5'd12, 5'd0, 16'h0020), 1'b0, 1'b0, '0,
			mk_issue(ALU_BRANCH, model[12], '0, 5'd0, 1'b0));
		add_row("j", pcj, encode_jump(OP_J, 26'h012_3456), 1'b0, 1'b1,
			jump_dest(pcj, 26'h012_3456), mk_issue(ALU_BRANCH, '0, '0, 5'd0, 1'b0));
		set_fwd('{1'b1, 5'd4, fa}, '0, 1'b0);
		add_row("jr fwd", PC0, encode_rtype(5'd4, 5'd0, 5'd0, FN_JR), 1'b0, 1'b1, fa,
			mk_issue(ALU_BRANCH, fa, '0, 5'd0, 1'b0));
		add_row("jal", pcj, encode_jump(OP_JAL, 26'h100_0040), 1'b0, 1'b1,
			jump_dest(pcj, 26'h100_0040),
			mk_issue(ALU_JAL, pcj + 32'd8, '0, reg_addr_t'(LINK_REG), 1'b1));

		add_row("lw", PC0, encode_itype(OP_LW, 5'd2, 5'd9, 16'hfffc), 1'b0, 1'b0, '0,
			mk_issue(ALU_LW, model[2], 32'hffff_fffc, 5'd9, 1'b1));
		set_fwd('{1'b1, 5'd7, fa}, '{1'b1, 5'd1, fb}, 1'b0);
		add_row("sw fwd", PC0, encode_itype(OP_SW, 5'd1, 5'd7, 16'h0020), 1'b0, 1'b0, '0,
			mk_issue(ALU_SW, fb + 32'h20, fa, 5'd0, 1'b0));
	endtask

	task automatic drive_row(input row_t r);
		wb_i         = r.wb;
		ex_fwd_i     = r.ex_fwd;
		mem_fwd_i    = r.mem_fwd;
		ex_is_load_i = r.ex_load;
		inst_valid_i = r.valid;
		pc_i         = r.pc;
		inst_i       = r.inst;
	endtask

	task automatic report_test(input string name);
		if (row_errors == 0) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: failed with %0d errors", name, row_errors);
		end
		row_errors = 0;
	endtask

	// registered side of a row, one clock after its edge
	task automatic finish_row(input int i);
		check_bit("ex_valid_o", ex_valid_o, rows[i].exp_valid);
		if (rows[i].exp_valid) begin
			check_issue("ex_o", ex_o, rows[i].exp_issue);
		end
		report_test(names[i]);
	endtask

	initial begin
		reset_i      = 1'b1;
		inst_valid_i = 1'b0;
		pc_i         = '0;
		inst_i       = '0;
		ex_fwd_i     = '0;
		mem_fwd_i    = '0;
		wb_i         = '0;
		ex_is_load_i = 1'b0;
		build_table();
		limit = 4 * rows.size() + 20;
		repeat (2) @(posedge clk);
		#1;
		reset_i = 1'b0;
		check_bit("ex_valid_o", ex_valid_o, 1'b0);
		check_bit("stall_o", stall_o, 1'b0);
		check_bit("branch_taken_o", branch_taken_o, 1'b0);
		check_issue("ex_o", ex_o, mk_issue(ALU_NOP, '0, '0, 5'd0, 1'b0));
		report_test("reset");
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clk);
			#1;
			if (i > 0) begin
				finish_row(i - 1);
			end
			drive_row(rows[i]);
			#4;
			check_bit("stall_o", stall_o, rows[i].exp_stall);
			check_bit("branch_taken_o", branch_taken_o, rows[i].exp_taken);
			check_word("branch_target_o", branch_target_o, rows[i].exp_target);
		end
		@(posedge clk);
		#1;
		finish_row(rows.size() - 1);
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			passed + failed, passed, failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		wait (limit != 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not end within %0d cycles", limit);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: all.f
rtl/id_pkg.sv
rtl/regfile.sv
rtl/inst_decoder.sv
rtl/forwarding_unit.sv
rtl/branch_resolver.sv
rtl/ex_issue_reg.sv
rtl/id_stage_top.sv
tests/tb_id_stage.sv
